// File: verif/spike_counter_vectors.txt
// len mask restart req0 req1 req2 req3 exp0 exp1 exp2 exp3 exp_ovf, all hex
// restart 1 stops run before the window; the all-zero record ends the list
// first window after run rises
0064 f 0 003 005 007 00a 03 05 07 0a 0
// shorter window, one silent channel
0050 f 0 001 000 004 002 01 00 04 02 0
// channel 0 driven past the all-ones count
07d0 f 0 104 003 000 001 ff 03 00 01 1
// overflow flag clears again
0064 f 0 006 002 002 002 06 02 02 02 0
// channels 1 and 3 masked
0064 5 0 004 004 004 004 04 00 04 00 0
// stop and restart, spikes while stopped are dropped
0064 f 1 002 003 004 005 02 03 04 05 0
// channels 0 and 2 masked
0078 a 0 007 008 009 003 00 08 00 03 0
// empty window
0064 f 0 000 000 000 000 00 00 00 00 0
// terminator
0000 0 0 000 000 000 000 00 00 00 00 0

// File: files.f
+incdir+include
design/spike_counter_pkg.sv
design/spike_edge_decode.sv
design/window_timer.sv
design/spike_count_execute.sv
design/window_result.sv
design/spike_counter_top.sv
verif/spike_counter_tb.sv

// File: Bender.yml
package:
  name: spike_counter

sources:
  # synthesizable design
  - include_dirs:
      - include
    files:
      - design/spike_counter_pkg.sv
      - design/spike_edge_decode.sv
      - design/window_timer.sv
      - design/spike_count_execute.sv
      - design/window_result.sv
      - design/spike_counter_top.sv

  # testbench
  - target: test
    include_dirs:
      - include
    files:
      - verif/spike_counter_tb.sv

// File: verif/spike_counter_tb.sv
`include "spike_counter_config.svh"

module spike_counter_tb;

    localparam int NUM_CH    = `SPIKE_NUM_CHANNELS;
    localparam int CW        = `SPIKE_COUNT_WIDTH;
    // words per vector record, see the vectors file header
    localparam int REC_WORDS = 12;
    // records in the file, the last one is the all-zero terminator
    localparam int MAX_RECS  = 9;
    localparam int SETTLE    = 20;

    logic                           clk;
    logic                           reset;
    spike_counter_pkg::chan_vec_t   spike;
    spike_counter_pkg::chan_vec_t   chan_mask;
    logic                           run;
    spike_counter_pkg::window_len_t window_len;
    spike_counter_pkg::count_vec_t  count_out;
    spike_counter_pkg::chan_vec_t   overflow_out;
    logic                           window_done;

    logic [31:0] vec_mem [0:REC_WORDS*MAX_RECS-1];
    // spikes to send per channel in the current train
    int req [0:NUM_CH-1];
    int cycle;
    // window_done pulses seen so far and the cycle of the last one
    int done_cnt;
    int last_done;
    int errors;
    int timeouts;

    spike_counter_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .spike        (spike),
        .chan_mask    (chan_mask),
        .run          (run),
        .window_len   (window_len),
        .count_out    (count_out),
        .overflow_out (overflow_out),
        .window_done  (window_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one clock, window_done sampled before the edge updates it
    task automatic step_cycle();
        @(posedge clk);
        cycle++;
        if (window_done === 1'b1) begin
            done_cnt++;
            last_done = cycle;
        end
    endtask

    task automatic check_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // bounded wait for the next window_done
    task automatic wait_window_done(input int limit, output bit ok);
        int start;
        int n;
        start = done_cnt;
        n = 0;
        while (done_cnt == start && n < limit) begin
            step_cycle();
            n++;
        end
        ok = (done_cnt != start);
        if (!ok) begin
            $display("timeout: no window_done within %0d cycles", limit);
            timeouts++;
        end
    endtask

    // pulses high 2 cycles, low 2 to 5 cycles, all channels in step
    task automatic send_spike_train();
        int longest;
        int low;
        spike_counter_pkg::chan_vec_t bits;
        longest = 0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (req[ch] > longest) begin
                longest = req[ch];
            end
        end
        for (int i = 0; i < longest; i++) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                bits[ch] = (i < req[ch]);
            end
            spike <= bits;
            step_cycle();
            step_cycle();
            spike <= '0;
            low = 2 + int'($urandom % 4);
            repeat (low) step_cycle();
        end
    endtask

    // drop run, spike while stopped, then start a fresh window
    task automatic restart_counting(input int base, input int next_base);
        int start;
        start = done_cnt;
        run        <= 1'b0;
        chan_mask  <= spike_counter_pkg::chan_vec_t'(vec_mem[base+1]);
        window_len <= spike_counter_pkg::window_len_t'(vec_mem[base]);
        // these must never reach a count
        for (int ch = 0; ch < NUM_CH; ch++) begin
            req[ch] = 3;
        end
        send_spike_train();
        // stay stopped longer than a whole window
        repeat (int'(vec_mem[base]) + SETTLE) step_cycle();
        assert (done_cnt == start) else begin
            $display("window_done pulsed while run was low");
            errors++;
        end
        run <= 1'b1;
        step_cycle();
        // timer has taken this record's length, queue the next one
        window_len <= spike_counter_pkg::window_len_t'(vec_mem[next_base]);
        repeat (3) step_cycle();
    endtask

    task automatic check_counts(input int base);
        logic [CW-1:0] got;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            got = count_out[ch*CW +: CW];
            check_hex($sformatf("count_out[%0d]", ch), 32'(got), vec_mem[base+7+ch]);
        end
        check_hex("overflow_out", 32'(overflow_out), vec_mem[base+11]);
    endtask

    initial begin
        int  rec;
        int  base;
        int  next_base;
        int  prev_done;
        int  start_cnt;
        bit  timed;
        bit  ok;
        void'($urandom(32'h3948));
        $readmemh("verif/spike_counter_vectors.txt", vec_mem);
        errors     = 0;
        timeouts   = 0;
        cycle      = 0;
        done_cnt   = 0;
        last_done  = 0;
        reset      = 1'b1;
        spike      = '0;
        chan_mask  = '0;
        run        = 1'b0;
        window_len = spike_counter_pkg::window_len_t'(vec_mem[0]);

        repeat (16) step_cycle();
        reset <= 1'b0;

        // idle after reset, nothing counted and no done
        repeat (SETTLE) step_cycle();
        check_hex("count_out", 32'(count_out), 32'h0);
        check_hex("overflow_out", 32'(overflow_out), 32'h0);
        assert (done_cnt == 0) else begin
            $display("window_done pulsed before run was raised");
            errors++;
        end

        rec = 0;
        while (rec < MAX_RECS && vec_mem[rec*REC_WORDS] != 0) begin
            base      = rec * REC_WORDS;
            next_base = (vec_mem[base+REC_WORDS] != 0) ? base + REC_WORDS : base;
            if (rec == 0 || vec_mem[base+2] != 0) begin
                // first window after run rises, no interval to compare
                restart_counting(base, next_base);
                timed = 1'b0;
            end else begin
                timed      = 1'b1;
                prev_done  = last_done;
                chan_mask  <= spike_counter_pkg::chan_vec_t'(vec_mem[base+1]);
                // applies from the window after this one
                window_len <= spike_counter_pkg::window_len_t'(vec_mem[next_base]);
                repeat (3) step_cycle();
            end
            start_cnt = done_cnt;
            for (int ch = 0; ch < NUM_CH; ch++) begin
                req[ch] = int'(vec_mem[base+3+ch]);
            end
            send_spike_train();
            assert (done_cnt == start_cnt) else begin
                $display("window %0d ended while its spikes were still being sent", rec);
                errors++;
            end
            wait_window_done(int'(vec_mem[base]) + 40, ok);
            if (ok) begin
                check_counts(base);
                if (timed) begin
                    check_hex("window_done interval", 32'(last_done - prev_done),
                              vec_mem[base]);
                end
            end
            rec++;
        end
        assert (rec > 0) else begin
            $display("no stimulus records were read from the vectors file");
            errors++;
        end

        $display("records %0d, errors %0d, timeouts %0d", rec, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: design/spike_counter_top.sv
module spike_counter_top (
    input  logic                            clk,
    input  logic                            reset,
    input  spike_counter_pkg::chan_vec_t    spike,
    input  spike_counter_pkg::chan_vec_t    chan_mask,
    input  logic                            run,
    input  spike_counter_pkg::window_len_t  window_len,
    output spike_counter_pkg::count_vec_t   count_out,
    output spike_counter_pkg::chan_vec_t    overflow_out,
    output logic                            window_done
);

    // decode to execute
    spike_counter_pkg::chan_vec_t  spike_pulse;
    // timer to execute
    logic                          window_end;
    // execute to result
    spike_counter_pkg::count_vec_t final_count;
    spike_counter_pkg::chan_vec_t  final_overflow;
    logic                          capture;

    // raw spike levels in, edge pulses out
    spike_edge_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .spike       (spike),
        .chan_mask   (chan_mask),
        .spike_pulse (spike_pulse)
    );

    // window boundary generator
    window_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .window_len (window_len),
        .window_end (window_end)
    );

    // per-channel counters
    spike_count_execute u_execute (
        .clk            (clk),
        .reset          (reset),
        .run            (run),
        .spike_pulse    (spike_pulse),
        .window_end     (window_end),
        .final_count    (final_count),
        .final_overflow (final_overflow),
        .capture        (capture)
    );

    // readout registers and done pulse
    window_result u_result (
        .clk            (clk),
        .reset          (reset),
        .final_count    (final_count),
        .final_overflow (final_overflow),
        .capture        (capture),
        .count_out      (count_out),
        .overflow_out   (overflow_out),
        .window_done    (window_done)
    );

endmodule

// File: design/window_result.sv
module window_result (
    input  logic                           clk,
    input  logic                           reset,
    input  spike_counter_pkg::count_vec_t  final_count,
    input  spike_counter_pkg::chan_vec_t   final_overflow,
    input  logic                           capture,
    output spike_counter_pkg::count_vec_t  count_out,
    output spike_counter_pkg::chan_vec_t   overflow_out,
    output logic                           window_done
);

    // readout register
    // holds the last finished window while the next one counts
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count_out    <= '0;
            overflow_out <= '0;
        end else if (capture) begin
            count_out    <= final_count;
            overflow_out <= final_overflow;
        end
    end

    // done goes high in the cycle the new values show up
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            window_done <= 1'b0;
        end else begin
            window_done <= capture;
        end
    end

    // one done per window
    a_done_single_cycle : assert property (
        @(posedge clk) disable iff (reset)
        window_done |-> !$past(window_done)
    ) else $error("window_done high two cycles in a row");

endmodule

// File: design/spike_count_execute.sv
`include "spike_counter_config.svh"

module spike_count_execute (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           run,
    input  spike_counter_pkg::chan_vec_t   spike_pulse,
    input  logic                           window_end,
    output spike_counter_pkg::count_vec_t  final_count,
    output spike_counter_pkg::chan_vec_t   final_overflow,
    output logic                           capture
);

    // running counts and flags of all channels, packed
    wire spike_counter_pkg::count_vec_t run_count;
    wire spike_counter_pkg::chan_vec_t  run_overflow;

    genvar ch;

    generate
        for (ch = 0; ch < `SPIKE_NUM_CHANNELS; ch++) begin : g_chan
            // this channel's count in the open window
            spike_counter_pkg::count_t count_q;
            // set once a pulse hit the all-ones count
            logic                      ovf_q;
            // count has reached its ceiling
            logic                      at_max;

            assign at_max = (count_q == '1);

            always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                    count_q <= '0;
                    ovf_q   <= 1'b0;
                end else if (!run) begin
                    // stopped, clear for the restart
                    count_q <= '0;
                    ovf_q   <= 1'b0;
                end else if (window_end) begin
                    // a pulse on the boundary belongs to the new window
                    count_q <= {{(`SPIKE_COUNT_WIDTH-1){1'b0}}, spike_pulse[ch]};
                    ovf_q   <= 1'b0;
                end else if (spike_pulse[ch]) begin
                    if (at_max) begin
                        // saturate and remember it
                        ovf_q <= 1'b1;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
            end

            assign run_count[ch*`SPIKE_COUNT_WIDTH +: `SPIKE_COUNT_WIDTH] = count_q;
            assign run_overflow[ch] = ovf_q;
        end
    endgenerate

    // snapshot of the closing window
    // capture flags the new snapshot one cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            final_count    <= '0;
            final_overflow <= '0;
            capture        <= 1'b0;
        end else begin
            capture <= window_end;
            if (window_end) begin
                final_count    <= run_count;
                final_overflow <= run_overflow;
            end
        end
    end

    // result stage relies on capture trailing window_end by one cycle
    a_capture_delay : assert property (
        @(posedge clk) disable iff (reset)
        capture == $past(window_end)
    ) else $error("capture %h does not follow window_end", capture);

endmodule

// File: design/window_timer.sv
`include "spike_counter_config.svh"

module window_timer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            run,
    input  spike_counter_pkg::window_len_t  window_len,
    output logic                            window_end
);

    // cycles elapsed in the current window, 1 based
    spike_counter_pkg::window_len_t cycle_cnt;
    // length in force for the current window
    spike_counter_pkg::window_len_t len_q;
    // set once the first window has started
    logic                           active;
    // start of a new window, on run rising or after a window end
    logic                           win_start;

    // last cycle of the window
    // run low keeps the pulse off even in the cycle run drops
    assign window_end = run & active & (cycle_cnt == len_q);

    assign win_start = run & (~active | window_end);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active    <= 1'b0;
            cycle_cnt <= '0;
            len_q     <= '0;
        end else if (!run) begin
            // stopped, next run starts a fresh window
            active    <= 1'b0;
            cycle_cnt <= '0;
        end else if (win_start) begin
            // new length applies from this window on
            active    <= 1'b1;
            cycle_cnt <= spike_counter_pkg::window_len_t'(1);
            len_q     <= window_len;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // shorter windows would let window_done overlap the next capture
    a_min_window : assert property (
        @(posedge clk) disable iff (reset)
        active |-> (len_q >= `SPIKE_MIN_WINDOW)
    ) else $error("captured window length too short: %h", len_q);

endmodule

// File: design/spike_edge_decode.sv
`include "spike_counter_config.svh"

module spike_edge_decode (
    input  logic                          clk,
    input  logic                          reset,
    input  spike_counter_pkg::chan_vec_t  spike,
    input  spike_counter_pkg::chan_vec_t  chan_mask,
    output spike_counter_pkg::chan_vec_t  spike_pulse
);

    // first synchronizer stage, may go metastable
    spike_counter_pkg::chan_vec_t sync_meta;
    // second stage, safe to use in logic
    spike_counter_pkg::chan_vec_t sync_level;
    // synchronized level one cycle earlier
    spike_counter_pkg::chan_vec_t sync_prev;
    // rising edge on enabled channels
    spike_counter_pkg::chan_vec_t rise_edge;

    // two flop synchronizer per channel
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_meta  <= '0;
            sync_level <= '0;
        end else begin
            sync_meta  <= spike;
            sync_level <= sync_meta;
        end
    end

    // low to high transition of the clean level
    // masked channels never produce an edge
    assign rise_edge = sync_level & ~sync_prev & chan_mask;

    // history flop and the pulse register
    // pulse appears on the third edge after the spike is first sampled
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_prev   <= '0;
            spike_pulse <= '0;
        end else begin
            sync_prev   <= sync_level;
            spike_pulse <= rise_edge;
        end
    end

    // each spike edge gives a single cycle pulse
    // back to back pulses on one channel would double count
    a_pulse_single_cycle : assert property (
        @(posedge clk) disable iff (reset)
        (spike_pulse & $past(spike_pulse)) == '0
    ) else $error("spike_pulse high two cycles in a row: %h", spike_pulse);

endmodule

// File: design/spike_counter_pkg.sv
`include "spike_counter_config.svh"

package spike_counter_pkg;

    // one bit per channel
    // spike levels, enable mask, edge pulses, overflow flags
    typedef logic [`SPIKE_NUM_CHANNELS-1:0] chan_vec_t;

    // a single channel count
    typedef logic [`SPIKE_COUNT_WIDTH-1:0] count_t;

    // all channel counts side by side
    // channel 0 sits in the low bits
    typedef logic [`SPIKE_NUM_CHANNELS*`SPIKE_COUNT_WIDTH-1:0] count_vec_t;

    // window length in clock cycles
    typedef logic [`SPIKE_TIMER_WIDTH-1:0] window_len_t;

endpackage

// File: include/spike_counter_config.svh
`ifndef SPIKE_COUNTER_CONFIG_SVH
`define SPIKE_COUNTER_CONFIG_SVH

// number of independent spike inputs
`define SPIKE_NUM_CHANNELS 4

// bits per channel count
// kept small so the all-ones value is easy to reach
`define SPIKE_COUNT_WIDTH 8

// bits of the programmable window length
`define SPIKE_TIMER_WIDTH 16

// shortest window the timer accepts
// must cover sync latency plus the capture and done stages
`define SPIKE_MIN_WINDOW 8

`endif
